// ==== build.f ====
+incdir+dv
source/conv_pkg.sv
source/conv_ctrl.sv
source/window_fetch.sv
source/weight_fetch.sv
source/mac_accum.sv
source/conv3x3_top.sv
dv/conv_tb.sv

// ==== dv/conv_model.svh ====
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

localparam int NUM_RUN  = 9;
localparam int MEM_SIZE = 256;

conv_pkg::pixel_t    in_mem  [MEM_SIZE];
conv_pkg::code_row_t wt_mem  [MEM_SIZE];
conv_pkg::qpix_t     exp_mem [MEM_SIZE];
int                  run_rows [NUM_RUN];
int                  run_chs  [NUM_RUN];
int                  n_row;
int                  n_ch;
conv_pkg::codebook_t cb_v;
conv_pkg::bias_vec_t bias_v;

// sizes drawn up front so the watchdog limit is known
task automatic draw_sizes();
  for (int r = 0; r < NUM_RUN; r++) begin
    run_rows[r] = 2 + $urandom % 5;
    run_chs[r]  = 1 + $urandom % 3;
  end
endtask

// last run: zero codebook, biases far positive or far negative
task automatic setup_run(int r);
  n_row = run_rows[r];
  n_ch  = run_chs[r];
  for (int a = 0; a < MEM_SIZE; a++) begin
    in_mem[a] = conv_pkg::pixel_t'($urandom);
    wt_mem[a] = conv_pkg::code_row_t'($urandom);
  end
  cb_v = $urandom;
  for (int k = 0; k < 4; k++) begin
    bias_v.b[k] = conv_pkg::psum_t'($urandom);
    if (r == NUM_RUN - 1) begin
      bias_v.b[k] = (k % 2 == 0) ? 16'h7f00 : 16'h8100;
    end
  end
  if (r == NUM_RUN - 1) begin
    cb_v = '0;
  end
endtask

function automatic int pixel_at(int c, int y, int x);
  if (y < 0 || y >= n_row || x < 0 || x >= n_row) begin
    return 0;
  end
  return int'(in_mem[c * n_row * n_row + y * n_row + x]);
endfunction

function automatic int weight_of(int k, int c, int t);
  logic [1:0]        code;
  logic signed [7:0] w;
  code = wt_mem[k * n_ch + c][2 * t +: 2];
  w    = cb_v[8 * code +: 8];
  return int'(w);
endfunction

// relu, saturate above bit 12, keep bits 12..5
function automatic conv_pkg::qpix_t requant(logic [15:0] s);
  if (s[15]) begin
    return 8'd0;
  end
  if (s[15:12] != 4'd0) begin
    return 8'd127;
  end
  return s[12:5];
endfunction

task automatic compute_expected();
  int sum;
  for (int k = 0; k < 4; k++) begin
    for (int y = 0; y < n_row; y++) begin
      for (int x = 0; x < n_row; x++) begin
        sum = int'(bias_v.b[k]);
        for (int c = 0; c < n_ch; c++) begin
          for (int t = 0; t < 9; t++) begin
            sum += pixel_at(c, y - 1 + t / 3, x - 1 + t % 3) * weight_of(k, c, t);
          end
        end
        exp_mem[k * n_row * n_row + y * n_row + x] = requant(sum[15:0]);
      end
    end
  end
endtask

function automatic int taps_in_image(int p);
  int py;
  int px;
  int cnt;
  py  = p / n_row;
  px  = p % n_row;
  cnt = 0;
  for (int t = 0; t < 9; t++) begin
    if (py - 1 + t / 3 >= 0 && py - 1 + t / 3 < n_row &&
        px - 1 + t % 3 >= 0 && px - 1 + t % 3 < n_row) begin
      cnt++;
    end
  end
  return cnt;
endfunction

`endif

// ==== dv/conv_tb.sv ====
`timescale 1ns/100ps

module conv_tb;

  localparam int CLK_PERIOD = 8;

  logic                clk;
  logic                rstn;
  logic                start;
  logic [4:0]          num_row;
  logic [3:0]          num_channel;
  conv_pkg::codebook_t codebook;
  conv_pkg::bias_vec_t bias;
  conv_pkg::addr_t     in_addr;
  logic                in_rd;
  conv_pkg::pixel_t    in_rdata;
  conv_pkg::addr_t     wt_addr;
  logic                wt_rd;
  conv_pkg::code_row_t wt_rdata;
  logic                out_we;
  conv_pkg::addr_t     out_addr;
  conv_pkg::qpix_t     out_data;
  logic                done;

  `include "conv_model.svh"

  int                  errors = 0;
  int                  checks = 0;
  int                  cyc = 0;
  int                  done_cnt;
  int                  wr_total;
  int                  last_wr_cyc;
  int                  rd_pix;
  int                  rd_ch;
  int                  rd_left;
  int                  limit_cycles;
  bit                  limit_ready = 1'b0;
  int                  wr_count [MEM_SIZE];
  conv_pkg::qpix_t     got_mem  [MEM_SIZE];
  logic                rd_q = 1'b0;
  logic                wt_q = 1'b0;
  conv_pkg::addr_t     rd_addr_q;
  conv_pkg::addr_t     wt_addr_q;

  conv3x3_top #(.ROW_W(5), .CHA_W(4)) conv3x3_top_inst (
    .clk(clk), .rstn(rstn), .start(start),
    .num_row(num_row), .num_channel(num_channel),
    .codebook(codebook), .bias(bias),
    .in_addr(in_addr), .in_rd(in_rd), .in_rdata(in_rdata),
    .wt_addr(wt_addr), .wt_rd(wt_rd), .wt_rdata(wt_rdata),
    .out_we(out_we), .out_addr(out_addr), .out_data(out_data), .done(done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic flag_error(string msg);
    errors++;
    $display("[FAIL] t=%0t: %s", $time, msg);
  endtask

  // reads come in channel order for each pixel, within its 3x3 neighbourhood
  task automatic check_read(int a);
    int plane;
    int c;
    int y;
    int x;
    plane = n_row * n_row;
    c     = a / plane;
    y     = (a % plane) / n_row;
    x     = a % n_row;
    if (c != rd_ch || y < rd_pix / n_row - 1 || y > rd_pix / n_row + 1 ||
        x < rd_pix % n_row - 1 || x > rd_pix % n_row + 1) begin
      flag_error($sformatf("read of address %0d, expected channel %0d near pixel %0d",
                           a, rd_ch, rd_pix));
    end
    rd_left--;
    if (rd_left == 0) begin
      if (rd_ch == n_ch - 1) begin
        rd_ch = 0;
        rd_pix++;
      end else begin
        rd_ch++;
      end
      rd_left = taps_in_image(rd_pix);
    end
  endtask

  task automatic record_write(int a, conv_pkg::qpix_t d);
    last_wr_cyc = cyc;
    wr_total++;
    if (a >= 4 * n_row * n_row) begin
      flag_error($sformatf("write to address %0d outside the output image", a));
    end else begin
      wr_count[a]++;
      got_mem[a] = d;
      checks++;
      if (d !== exp_mem[a]) begin
        flag_error($sformatf("out[%0d] got %0d, expected %0d", a, d, exp_mem[a]));
      end
    end
  endtask

  // memory responders and output monitor, all mid-cycle
  always @(negedge clk) begin
    cyc++;
    if (rd_q) in_rdata = in_mem[rd_addr_q];
    if (wt_q) wt_rdata = wt_mem[wt_addr_q];
    rd_q      = in_rd;
    rd_addr_q = in_addr;
    wt_q      = wt_rd;
    wt_addr_q = wt_addr;
    if (in_rd) check_read(in_addr);
    if (out_we) record_write(out_addr, out_data);
    if (done) begin
      done_cnt++;
      if (cyc != last_wr_cyc + 1 || wr_total != 4 * n_row * n_row) begin
        flag_error("done did not follow the last output write");
      end
    end
  end

  task automatic run_one(int r);
    int plane;
    setup_run(r);
    compute_expected();
    plane = n_row * n_row;
    for (int a = 0; a < MEM_SIZE; a++) begin
      wr_count[a] = 0;
    end
    done_cnt    = 0;
    wr_total    = 0;
    last_wr_cyc = -10;
    rd_pix      = 0;
    rd_ch       = 0;
    rd_left     = taps_in_image(0);
    @(negedge clk);
    num_row     = 5'(n_row);
    num_channel = 4'(n_ch);
    codebook    = cb_v;
    bias        = bias_v;
    start       = 1'b1;
    @(negedge clk);
    start = 1'b0;
    repeat (3) @(negedge clk);
    // restart with junk while busy must be ignored
    num_row     = $urandom;
    num_channel = $urandom;
    codebook    = $urandom;
    bias        = {$urandom, $urandom};
    start       = 1'b1;
    @(negedge clk);
    start = 1'b0;
    wait (done_cnt != 0);
    repeat (6) @(negedge clk);
    if (done_cnt != 1) begin
      flag_error($sformatf("done pulsed %0d times in run %0d", done_cnt, r));
    end
    for (int a = 0; a < 4 * plane; a++) begin
      if (wr_count[a] != 1) begin
        flag_error($sformatf("address %0d written %0d times", a, wr_count[a]));
      end else if (r == NUM_RUN - 1 && got_mem[a] != ((a / plane) % 2 == 0 ? 8'd127 : 8'd0)) begin
        flag_error($sformatf("forced bias out[%0d] got %0d", a, got_mem[a]));
      end
    end
  endtask

  initial begin
    rstn        = 1'b0;
    start       = 1'b0;
    num_row     = '0;
    num_channel = '0;
    codebook    = '0;
    bias        = '0;
    in_rdata    = '0;
    wt_rdata    = '0;
    void'($urandom(32'ha594));
    draw_sizes();
    limit_cycles = 1000;
    for (int r = 0; r < NUM_RUN; r++) begin
      limit_cycles += 20 * run_rows[r] * run_rows[r] * run_chs[r] + 10 * run_rows[r] * run_rows[r];
    end
    limit_ready = 1'b1;
    repeat (2) @(negedge clk);
    rstn = 1'b1;
    for (int r = 0; r < NUM_RUN; r++) begin
      run_one(r);
    end
    $display("runs %0d, writes checked %0d, errors %0d", NUM_RUN, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    wait (limit_ready);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: runs did not finish within %0d cycles", limit_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== source/conv3x3_top.sv ====
`timescale 1ns/100ps

module conv3x3_top #(
  parameter int ROW_W = 5,
  parameter int CHA_W = 4
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  start,
  input  logic [ROW_W-1:0]      num_row,
  input  logic [CHA_W-1:0]      num_channel,
  input  conv_pkg::codebook_t   codebook,
  input  conv_pkg::bias_vec_t   bias,
  output conv_pkg::addr_t       in_addr,
  output logic                  in_rd,
  input  conv_pkg::pixel_t      in_rdata,
  output conv_pkg::addr_t       wt_addr,
  output logic                  wt_rd,
  input  conv_pkg::code_row_t   wt_rdata,
  output logic                  out_we,
  output conv_pkg::addr_t       out_addr,
  output conv_pkg::qpix_t       out_data,
  output logic                  done
);

  logic                accept;
  logic [ROW_W-1:0]    row_cnt;
  logic                fetch_go;
  logic [ROW_W-1:0]    pos_x;
  logic [ROW_W-1:0]    pos_y;
  logic [CHA_W-1:0]    cha;
  logic                win_done;
  logic                wt_done;
  logic                mac_go;
  logic                acc_first;
  conv_pkg::window_t   window;
  conv_pkg::kernel_w_t weights;
  conv_pkg::qvec_t     qres;

  conv_ctrl #(.ROW_W(ROW_W), .CHA_W(CHA_W)) conv_ctrl_inst (
    .clk(clk), .rstn(rstn), .start(start),
    .num_row(num_row), .num_channel(num_channel),
    .accept(accept), .row_cnt(row_cnt),
    .fetch_go(fetch_go), .pos_x(pos_x), .pos_y(pos_y), .cha(cha),
    .win_done(win_done), .wt_done(wt_done),
    .mac_go(mac_go), .acc_first(acc_first), .qres(qres),
    .out_we(out_we), .out_addr(out_addr), .out_data(out_data), .done(done)
  );

  window_fetch #(.ROW_W(ROW_W), .CHA_W(CHA_W)) window_fetch_inst (
    .clk(clk), .rstn(rstn), .fetch_go(fetch_go),
    .pos_x(pos_x), .pos_y(pos_y), .cha(cha), .row_cnt(row_cnt),
    .in_addr(in_addr), .in_rd(in_rd), .in_rdata(in_rdata),
    .win_done(win_done), .window(window)
  );

  weight_fetch #(.CHA_W(CHA_W)) weight_fetch_inst (
    .clk(clk), .rstn(rstn), .start(accept), .codebook(codebook),
    .fetch_go(fetch_go), .cha(cha), .num_channel(num_channel),
    .wt_addr(wt_addr), .wt_rd(wt_rd), .wt_rdata(wt_rdata),
    .wt_done(wt_done), .weights(weights)
  );

  mac_accum mac_accum_inst (
    .clk(clk), .rstn(rstn), .start(accept), .bias(bias),
    .mac_go(mac_go), .acc_first(acc_first),
    .window(window), .weights(weights), .qres(qres)
  );

endmodule

// ==== source/conv_ctrl.sv ====
`timescale 1ns/100ps

module conv_ctrl #(
  parameter int ROW_W = 5,
  parameter int CHA_W = 4
) (
  input  logic               clk,
  input  logic               rstn,
  input  logic               start,
  input  logic [ROW_W-1:0]   num_row,
  input  logic [CHA_W-1:0]   num_channel,
  output logic               accept,
  output logic [ROW_W-1:0]   row_cnt,
  output logic               fetch_go,
  output logic [ROW_W-1:0]   pos_x,
  output logic [ROW_W-1:0]   pos_y,
  output logic [CHA_W-1:0]   cha,
  input  logic               win_done,
  input  logic               wt_done,
  output logic               mac_go,
  output logic               acc_first,
  input  conv_pkg::qvec_t    qres,
  output logic               out_we,
  output conv_pkg::addr_t    out_addr,
  output conv_pkg::qpix_t    out_data,
  output logic               done
);

  conv_pkg::ctrl_state_t state;
  logic [CHA_W-1:0]      cha_last;
  logic [1:0]            kidx;
  logic                  win_seen;
  logic                  wt_seen;
  logic                  both_ready;
  logic                  last_x;
  logic                  last_y;
  conv_pkg::addr_t       plane;
  conv_pkg::addr_t       pix_off;

  // start only counts when idle
  assign accept     = start && (state == conv_pkg::idle);
  assign both_ready = (win_seen || win_done) && (wt_seen || wt_done);
  assign last_x     = (pos_x == row_cnt - 1'b1);
  assign last_y     = (pos_y == row_cnt - 1'b1);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= conv_pkg::idle;
      fetch_go  <= 1'b0;
      mac_go    <= 1'b0;
      acc_first <= 1'b0;
      win_seen  <= 1'b0;
      wt_seen   <= 1'b0;
      pos_x     <= '0;
      pos_y     <= '0;
      cha       <= '0;
      kidx      <= '0;
      row_cnt   <= '0;
      cha_last  <= '0;
      plane     <= '0;
    end else begin
      fetch_go <= 1'b0;
      mac_go   <= 1'b0;
      case (state)
        conv_pkg::idle: begin
          if (start) begin
            row_cnt  <= num_row;
            cha_last <= num_channel - 1'b1;
            plane    <= conv_pkg::addr_t'(num_row) * conv_pkg::addr_t'(num_row);
            pos_x    <= '0;
            pos_y    <= '0;
            cha      <= '0;
            fetch_go <= 1'b1;
            state    <= conv_pkg::fetch;
          end
        end
        conv_pkg::fetch: begin
          if (both_ready) begin
            win_seen  <= 1'b0;
            wt_seen   <= 1'b0;
            mac_go    <= 1'b1;
            acc_first <= (cha == '0);
            // next channel fetch overlaps this accumulate
            if (cha == cha_last) begin
              state <= conv_pkg::mac;
            end else begin
              cha      <= cha + 1'b1;
              fetch_go <= 1'b1;
            end
          end else begin
            if (win_done) win_seen <= 1'b1;
            if (wt_done) wt_seen <= 1'b1;
          end
        end
        conv_pkg::mac: begin
          kidx  <= '0;
          state <= conv_pkg::write;
        end
        conv_pkg::write: begin
          kidx <= kidx + 1'b1;
          if (kidx == 2'd3) begin
            if (last_x && last_y) begin
              state <= conv_pkg::done_pulse;
            end else begin
              pos_x    <= last_x ? '0 : pos_x + 1'b1;
              pos_y    <= last_x ? pos_y + 1'b1 : pos_y;
              cha      <= '0;
              fetch_go <= 1'b1;
              state    <= conv_pkg::fetch;
            end
          end
        end
        default: state <= conv_pkg::idle;
      endcase
    end
  end

  // kernel-major output layout
  assign pix_off  = conv_pkg::addr_t'(pos_y) * conv_pkg::addr_t'(row_cnt)
                  + conv_pkg::addr_t'(pos_x);
  assign out_addr = conv_pkg::addr_t'(kidx) * plane + pix_off;
  assign out_data = qres.q[kidx];
  assign out_we   = (state == conv_pkg::write);
  assign done     = (state == conv_pkg::done_pulse);

  a_min_rows: assert property (@(posedge clk) disable iff (!rstn)
    accept |-> num_row >= 2)
    else $error("image narrower than two rows");

  a_done_in_fetch: assert property (@(posedge clk) disable iff (!rstn)
    (win_done || wt_done) |-> state == conv_pkg::fetch)
    else $error("fetch completion outside fetch state");

endmodule

// ==== source/conv_pkg.sv ====
package conv_pkg;

  // signed pixel, also used for decoded weights
  typedef logic signed [7:0]  pixel_t;
  // nine 2-bit codes, tap 0 in the low bits
  typedef logic [17:0]        code_row_t;
  // four signed bytes, code 0 in the low byte
  typedef logic [31:0]        codebook_t;
  typedef logic signed [15:0] psum_t;
  typedef logic [15:0]        addr_t;
  typedef logic [7:0]         qpix_t;

  localparam int NUM_KERNEL  = 4;
  localparam int NUM_TAP     = 9;
  localparam int QUANT_SHIFT = 5;
  localparam qpix_t QUANT_MAX = 8'd127;

  // 3x3 window, row-major from top-left
  typedef struct packed {
    pixel_t [NUM_TAP-1:0] tap;
  } window_t;

  // one 3x3 weight set per kernel
  typedef struct packed {
    pixel_t [NUM_KERNEL-1:0][NUM_TAP-1:0] w;
  } kernel_w_t;

  typedef struct packed {
    psum_t [NUM_KERNEL-1:0] b;
  } bias_vec_t;

  typedef struct packed {
    qpix_t [NUM_KERNEL-1:0] q;
  } qvec_t;

  typedef enum logic [2:0] {
    idle,
    fetch,
    mac,
    write,
    done_pulse
  } ctrl_state_t;

endpackage

// ==== source/mac_accum.sv ====
`timescale 1ns/100ps

module mac_accum (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 start,
  input  conv_pkg::bias_vec_t  bias,
  input  logic                 mac_go,
  input  logic                 acc_first,
  input  conv_pkg::window_t    window,
  input  conv_pkg::kernel_w_t  weights,
  output conv_pkg::qvec_t      qres
);

  conv_pkg::bias_vec_t bias_q;
  conv_pkg::psum_t     dot [conv_pkg::NUM_KERNEL];
  conv_pkg::psum_t     acc [conv_pkg::NUM_KERNEL];

  // nine-term dot product per kernel, wraps at 16 bits
  always_comb begin
    for (int k = 0; k < conv_pkg::NUM_KERNEL; k++) begin
      dot[k] = '0;
      for (int i = 0; i < conv_pkg::NUM_TAP; i++) begin
        dot[k] = dot[k]
               + conv_pkg::psum_t'($signed(window.tap[i]))
               * conv_pkg::psum_t'($signed(weights.w[k][i]));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) bias_q <= bias;
    if (mac_go) begin
      for (int k = 0; k < conv_pkg::NUM_KERNEL; k++) begin
        // first channel restarts from the bias
        acc[k] <= (acc_first ? bias_q.b[k] : acc[k]) + dot[k];
      end
    end
  end

  // relu, then saturate and shift down
  always_comb begin
    for (int k = 0; k < conv_pkg::NUM_KERNEL; k++) begin
      if (acc[k][15]) begin
        qres.q[k] = '0;
      end else if (|acc[k][15:12]) begin
        qres.q[k] = conv_pkg::QUANT_MAX;
      end else begin
        qres.q[k] = acc[k][conv_pkg::QUANT_SHIFT +: 8];
      end
    end
  end

  a_go_not_start: assert property (@(posedge clk) disable iff (!rstn)
    !(mac_go && start))
    else $error("accumulate requested during run start");

endmodule

// ==== source/weight_fetch.sv ====
`timescale 1ns/100ps

module weight_fetch #(
  parameter int CHA_W = 4
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 start,
  input  conv_pkg::codebook_t  codebook,
  input  logic                 fetch_go,
  input  logic [CHA_W-1:0]     cha,
  input  logic [CHA_W-1:0]     num_channel,
  output conv_pkg::addr_t      wt_addr,
  output logic                 wt_rd,
  input  conv_pkg::code_row_t  wt_rdata,
  output logic                 wt_done,
  output conv_pkg::kernel_w_t  weights
);

  conv_pkg::codebook_t cb;
  logic [CHA_W-1:0]    nch;
  logic                busy;
  logic [1:0]          kcnt;
  logic [1:0]          cur_k;
  logic [1:0]          k_q;
  logic                rd_q;
  conv_pkg::window_t   decoded;

  // held for the whole run
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cb  <= '0;
      nch <= '0;
    end else if (start) begin
      cb  <= codebook;
      nch <= num_channel;
    end
  end

  // kernel 0 is read in the fetch_go cycle itself
  assign cur_k   = busy ? kcnt : 2'd0;
  assign wt_rd   = fetch_go || busy;
  assign wt_addr = conv_pkg::addr_t'(cur_k) * conv_pkg::addr_t'(nch)
                 + conv_pkg::addr_t'(cha);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy    <= 1'b0;
      kcnt    <= '0;
      rd_q    <= 1'b0;
      k_q     <= '0;
      wt_done <= 1'b0;
    end else begin
      rd_q    <= wt_rd;
      k_q     <= cur_k;
      wt_done <= rd_q && (k_q == 2'd3);
      if (fetch_go) begin
        busy <= 1'b1;
        kcnt <= 2'd1;
      end else if (busy) begin
        kcnt <= kcnt + 1'b1;
        if (kcnt == 2'd3) busy <= 1'b0;
      end
    end
  end

  // code picks a byte of the codebook
  always_comb begin
    for (int i = 0; i < conv_pkg::NUM_TAP; i++) begin
      decoded.tap[i] = cb[{wt_rdata[2*i +: 2], 3'b000} +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (rd_q) weights.w[k_q] <= decoded.tap;
  end

endmodule

// ==== source/window_fetch.sv ====
`timescale 1ns/100ps

module window_fetch #(
  parameter int ROW_W = 5,
  parameter int CHA_W = 4
) (
  input  logic               clk,
  input  logic               rstn,
  input  logic               fetch_go,
  input  logic [ROW_W-1:0]   pos_x,
  input  logic [ROW_W-1:0]   pos_y,
  input  logic [CHA_W-1:0]   cha,
  input  logic [ROW_W-1:0]   row_cnt,
  output conv_pkg::addr_t    in_addr,
  output logic               in_rd,
  input  conv_pkg::pixel_t   in_rdata,
  output logic               win_done,
  output conv_pkg::window_t  window
);

  // tap coordinates offset by one so the top/left pad is zero
  typedef logic [ROW_W:0] coord_t;

  coord_t                       tap_r [conv_pkg::NUM_TAP];
  coord_t                       tap_c [conv_pkg::NUM_TAP];
  logic [conv_pkg::NUM_TAP-1:0] in_img;
  logic [conv_pkg::NUM_TAP-1:0] pending;
  logic [conv_pkg::NUM_TAP-1:0] pending_nxt;
  logic [3:0]                   sel;
  logic [3:0]                   tap_q;
  logic                         rd_q;
  logic                         last_q;
  conv_pkg::addr_t              plane;

  always_comb begin
    for (int t = 0; t < conv_pkg::NUM_TAP; t++) begin
      tap_r[t]  = coord_t'(pos_y) + coord_t'(t / 3);
      tap_c[t]  = coord_t'(pos_x) + coord_t'(t % 3);
      in_img[t] = (tap_r[t] != '0) && (tap_r[t] <= coord_t'(row_cnt)) &&
                  (tap_c[t] != '0) && (tap_c[t] <= coord_t'(row_cnt));
    end
  end

  // lowest pending tap goes next
  always_comb begin
    sel = '0;
    for (int t = conv_pkg::NUM_TAP - 1; t >= 0; t--) begin
      if (pending[t]) sel = 4'(t);
    end
  end

  assign pending_nxt = pending & ~(conv_pkg::NUM_TAP'(1) << sel);
  assign in_rd       = |pending;
  assign plane       = conv_pkg::addr_t'(row_cnt) * conv_pkg::addr_t'(row_cnt);
  assign in_addr     = conv_pkg::addr_t'(cha) * plane
                     + conv_pkg::addr_t'(tap_r[sel] - 1'b1) * conv_pkg::addr_t'(row_cnt)
                     + conv_pkg::addr_t'(tap_c[sel] - 1'b1);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pending  <= '0;
      rd_q     <= 1'b0;
      last_q   <= 1'b0;
      win_done <= 1'b0;
    end else begin
      rd_q     <= in_rd;
      last_q   <= in_rd && (pending_nxt == '0);
      // all-padding window finishes right away
      win_done <= (fetch_go && (in_img == '0)) || (rd_q && last_q);
      pending  <= fetch_go ? in_img : pending_nxt;
    end
  end

  always_ff @(posedge clk) begin
    tap_q <= sel;
    if (fetch_go) begin
      for (int t = 0; t < conv_pkg::NUM_TAP; t++) begin
        if (!in_img[t]) window.tap[t] <= '0;
      end
    end else if (rd_q) begin
      window.tap[tap_q] <= in_rdata;
    end
  end

  a_read_in_image: assert property (@(posedge clk) disable iff (!rstn)
    in_rd |-> in_img[sel])
    else $error("input read outside the image");

endmodule
